/* dma_thread.f */
+incdir+include
rtl/dma_pkg.sv
rtl/dma_tag_table.sv
rtl/dma_fetch_ctrl.sv
rtl/dma_write_path.sv
rtl/dma_thread.sv
testbench/dma_mem_model.sv
testbench/dma_thread_asserts.sv
testbench/dma_thread_tb.sv

/* include/dma_defs.svh */
`ifndef DMA_DEFS_SVH
`define DMA_DEFS_SVH

// Ring bus widths
`define DMA_ADDR_W       32
`define DMA_DATA_W       64
`define DMA_MASK_W       8

// log2 of the 4-byte word
`define DMA_WORD_OFFSET  2

// Word counter, 1 MB of 4-byte words
`define DMA_CNT_W        18

// Repeat pass counter
`define DMA_RPT_W        4

// Tag table
`define DMA_SLOT_W       4
`define DMA_NUM_SLOTS    16
`define DMA_THREAD_ID_W  2

`endif

/* rtl/dma_fetch_ctrl.sv */
`default_nettype none
`timescale 1ns/1ps

`include "dma_defs.svh"

module dma_fetch_ctrl
  import dma_pkg::*;
#(
  parameter logic [`DMA_THREAD_ID_W-1:0] THREAD_ID = '0
) (
  input  wire logic                    clk,
  input  wire logic                    rstn,
  input  wire dma_cfg_t                cfg,
  input  wire logic                    start,

  output logic                         rd_req_vld,
  output dma_req_t                     rd_req,
  input  wire logic                    rd_req_rdy,

  output logic                         alloc_req,
  output logic                         alloc_take,
  output logic      [`DMA_CNT_W-1:0]   take_offset,
  input  wire logic                    slot_free,
  input  wire logic [`DMA_SLOT_W-1:0]  free_slot,
  input  wire logic                    table_empty,

  output logic                         done,
  output logic                         idle
);

  localparam int PAD_W = `DMA_ADDR_W - `DMA_CNT_W - `DMA_WORD_OFFSET;

  fetch_state_e              rff_state, next_state;
  logic [`DMA_CNT_W-1:0]     rff_idx, next_idx;
  logic [`DMA_CNT_W-1:0]     rff_grp, next_grp;
  logic [`DMA_CNT_W-1:0]     rff_tot, next_tot;
  logic [`DMA_RPT_W-1:0]     rff_rpt, next_rpt;

  logic [`DMA_CNT_W-1:0]     step;
  logic [`DMA_CNT_W-1:0]     len_words;
  logic [`DMA_CNT_W-1:0]     req_words;
  logic [`DMA_CNT_W-1:0]     grp_words;
  logic [`DMA_CNT_W-1:0]     stride_words;

  // ======================================================================
  // Command decode

  assign step         = cfg.use_8b ? `DMA_CNT_W'(2) : `DMA_CNT_W'(1);
  assign len_words    = cfg.length_bytes[`DMA_WORD_OFFSET +: `DMA_CNT_W];
  assign grp_words    = cfg.grp_depth[`DMA_WORD_OFFSET +: `DMA_CNT_W];
  assign stride_words = cfg.stride[`DMA_WORD_OFFSET +: `DMA_CNT_W];

  // Round the length up to whole elements
  always_comb begin
    if (!cfg.use_8b) begin
      if (cfg.length_bytes[`DMA_WORD_OFFSET-1:0] == '0) begin
        req_words = len_words;
      end else begin
        req_words = len_words + `DMA_CNT_W'(1);
      end
    end else begin
      if (cfg.length_bytes[`DMA_WORD_OFFSET:0] == '0) begin
        req_words = len_words;
      end else begin
        req_words = {len_words[`DMA_CNT_W-1:1], 1'b0} + `DMA_CNT_W'(2);
      end
    end
  end

  // ======================================================================
  // Fetch FSM

  always_ff @(posedge clk) begin
    if (!rstn) begin
      rff_state <= ST_IDLE;
      rff_idx   <= '0;
      rff_grp   <= '0;
      rff_tot   <= '0;
      rff_rpt   <= '0;
    end else begin
      rff_state <= next_state;
      rff_idx   <= next_idx;
      rff_grp   <= next_grp;
      rff_tot   <= next_tot;
      rff_rpt   <= next_rpt;
    end
  end

  always_comb begin
    next_state = rff_state;
    next_idx   = rff_idx;
    next_grp   = rff_grp;
    next_tot   = rff_tot;
    next_rpt   = rff_rpt;
    done       = 1'b0;
    case (rff_state)
      ST_IDLE: begin
        if (start) begin
          next_state = ST_GET_TAG;
          next_idx   = '0;
          next_grp   = '0;
          next_tot   = '0;
          next_rpt   = '0;
        end
      end
      ST_GET_TAG: begin
        if (slot_free) begin
          next_state = ST_FETCH_REQ;
        end
      end
      ST_FETCH_REQ: begin
        if (rd_req_rdy) begin
          next_grp = rff_grp + step;
          next_tot = rff_tot + step;
          if (next_grp == grp_words) begin
            next_grp = '0;
            next_idx = rff_idx + step + stride_words - grp_words;  // Skip to next group
          end else begin
            next_idx = rff_idx + step;
          end
          if (next_idx >= req_words) begin
            next_state = ST_FETCH_DONE;
          end else begin
            next_state = ST_GET_TAG;
          end
        end
      end
      ST_FETCH_DONE: begin
        if (table_empty) begin
          if (rff_rpt == cfg.rpt_less_1) begin
            done       = 1'b1;
            next_state = ST_IDLE;
          end else begin
            next_rpt   = rff_rpt + 1'b1;  // Total count keeps running
            next_idx   = '0;
            next_grp   = '0;
            next_state = ST_GET_TAG;
          end
        end
      end
      default: begin
        next_state = ST_IDLE;
      end
    endcase
  end

  // ======================================================================
  // Read request

  assign rd_req_vld  = (rff_state == ST_FETCH_REQ);
  assign alloc_req   = (rff_state == ST_GET_TAG);
  assign alloc_take  = rd_req_vld & rd_req_rdy;
  assign take_offset = rff_tot;
  assign idle        = (rff_state == ST_IDLE);

  always_comb begin
    rd_req               = '0;
    rd_req.tag.thread_id = THREAD_ID;
    rd_req.tag.slot      = free_slot;
    rd_req.req_type      = REQ_READ;
    rd_req.addr          = cfg.src_addr + {{PAD_W{1'b0}}, rff_idx, {`DMA_WORD_OFFSET{1'b0}}};
    rd_req.mask          = '1;
  end

endmodule

`default_nettype wire

/* rtl/dma_pkg.sv */
`default_nettype none

`include "dma_defs.svh"

package dma_pkg;

  typedef enum logic [1:0] {
    ST_IDLE       = 2'b00,
    ST_GET_TAG    = 2'b01,
    ST_FETCH_REQ  = 2'b10,
    ST_FETCH_DONE = 2'b11
  } fetch_state_e;

  typedef enum logic {
    REQ_READ  = 1'b0,
    REQ_WRITE = 1'b1
  } req_type_e;

  typedef enum logic {
    MODE_PREFETCH = 1'b0,         // Source equals destination
    MODE_RW       = 1'b1
  } dma_mode_e;

  typedef struct packed {
    logic [`DMA_THREAD_ID_W-1:0] thread_id;
    logic [`DMA_SLOT_W-1:0]      slot;
  } dma_tag_t;

  typedef struct packed {
    dma_tag_t                tag;
    req_type_e               req_type;
    logic [`DMA_ADDR_W-1:0]  addr;
    logic [`DMA_DATA_W-1:0]  wdata;
    logic [`DMA_MASK_W-1:0]  mask;
  } dma_req_t;

  typedef struct packed {
    dma_tag_t                tag;
    logic [`DMA_DATA_W-1:0]  rdata;
  } dma_rsp_t;

  typedef struct packed {
    logic [`DMA_ADDR_W-1:0]  src_addr;      // Aligned to element size
    logic [`DMA_ADDR_W-1:0]  dst_addr;      // Aligned to element size
    logic [`DMA_ADDR_W-1:0]  length_bytes;
    logic                    use_8b;
    logic [`DMA_RPT_W-1:0]   rpt_less_1;
    logic [`DMA_ADDR_W-1:0]  grp_depth;     // Bytes, multiple of element size
    logic [`DMA_ADDR_W-1:0]  stride;        // Bytes, multiple of element size
  } dma_cfg_t;

endpackage

`default_nettype wire

/* rtl/dma_tag_table.sv */
`default_nettype none
`timescale 1ns/1ps

`include "dma_defs.svh"

module dma_tag_table (
  input  wire logic                    clk,
  input  wire logic                    rstn,

  input  wire logic                    alloc_req,     // Fetch FSM waiting for a slot
  input  wire logic                    take,
  input  wire logic [`DMA_CNT_W-1:0]   take_offset,
  output logic      [`DMA_SLOT_W-1:0]  free_slot,
  output logic                         slot_free,
  output logic                         empty,

  input  wire logic                    clear,
  input  wire logic [`DMA_SLOT_W-1:0]  clear_slot,
  output logic      [`DMA_CNT_W-1:0]   clear_offset
);

  logic [`DMA_NUM_SLOTS-1:0]                  in_use;
  logic [`DMA_NUM_SLOTS-1:0][`DMA_CNT_W-1:0]  offsets;
  logic [`DMA_SLOT_W-1:0]                     low_slot;
  logic [`DMA_SLOT_W-1:0]                     set_slot;

  // ======================================================================
  // Slot selection

  always_comb begin
    low_slot = '0;
    for (int i = `DMA_NUM_SLOTS-1; i >= 0; i--) begin
      if (!in_use[i]) begin
        low_slot = `DMA_SLOT_W'(i);    // Lowest index wins
      end
    end
  end

  // Held steady while the read request waits for ready
  always_ff @(posedge clk) begin
    if (alloc_req && slot_free) begin
      set_slot <= low_slot;
    end
  end

  // ======================================================================
  // In-use bits and stored offsets

  always_ff @(posedge clk) begin
    if (!rstn) begin
      in_use <= '0;
    end else begin
      if (take) begin
        in_use[set_slot] <= 1'b1;
      end
      if (clear) begin
        in_use[clear_slot] <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      offsets[set_slot] <= take_offset;
    end
  end

  assign free_slot    = set_slot;
  assign slot_free    = |(~in_use);
  assign empty        = ~(|in_use);
  assign clear_offset = offsets[clear_slot];  // Destination word offset of the responding tag

endmodule

`default_nettype wire

/* rtl/dma_thread.sv */
`default_nettype none
`timescale 1ns/1ps

`include "dma_defs.svh"

module dma_thread
  import dma_pkg::*;
#(
  parameter logic [`DMA_THREAD_ID_W-1:0] THREAD_ID = '0
) (
  input  wire logic      clk,
  input  wire logic      rstn,

  input  wire dma_cfg_t  cfg,           // Stable from start until done
  input  wire logic      start,

  output logic           rd_req_vld,
  output dma_req_t       rd_req,
  input  wire logic      rd_req_rdy,

  input  wire logic      rd_rsp_vld,
  input  wire dma_rsp_t  rd_rsp,
  output logic           rd_rsp_rdy,

  output logic           wr_req_vld,
  output dma_req_t       wr_req,
  input  wire logic      wr_req_rdy,

  output logic           done,
  output logic           idle
);

  logic                    alloc_req;
  logic                    alloc_take;
  logic [`DMA_CNT_W-1:0]   take_offset;
  logic                    slot_free;
  logic [`DMA_SLOT_W-1:0]  free_slot;
  logic                    table_empty;
  logic                    clear;
  logic [`DMA_SLOT_W-1:0]  clear_slot;
  logic [`DMA_CNT_W-1:0]   clear_offset;

  // ======================================================================
  // Read side

  dma_fetch_ctrl #(
    .THREAD_ID   (THREAD_ID)
  ) u_fetch (
    .clk         (clk),
    .rstn        (rstn),
    .cfg         (cfg),
    .start       (start),
    .rd_req_vld  (rd_req_vld),
    .rd_req      (rd_req),
    .rd_req_rdy  (rd_req_rdy),
    .alloc_req   (alloc_req),
    .alloc_take  (alloc_take),
    .take_offset (take_offset),
    .slot_free   (slot_free),
    .free_slot   (free_slot),
    .table_empty (table_empty),
    .done        (done),
    .idle        (idle)
  );

  dma_tag_table u_tags (
    .clk          (clk),
    .rstn         (rstn),
    .alloc_req    (alloc_req),
    .take         (alloc_take),
    .take_offset  (take_offset),
    .free_slot    (free_slot),
    .slot_free    (slot_free),
    .empty        (table_empty),
    .clear        (clear),
    .clear_slot   (clear_slot),
    .clear_offset (clear_offset)
  );

  // ======================================================================
  // Write side

  dma_write_path #(
    .THREAD_ID    (THREAD_ID)
  ) u_wr (
    .cfg          (cfg),
    .rd_rsp_vld   (rd_rsp_vld),
    .rd_rsp       (rd_rsp),
    .rd_rsp_rdy   (rd_rsp_rdy),
    .wr_req_vld   (wr_req_vld),
    .wr_req       (wr_req),
    .wr_req_rdy   (wr_req_rdy),
    .clear        (clear),
    .clear_slot   (clear_slot),
    .clear_offset (clear_offset)
  );

endmodule

`default_nettype wire

/* rtl/dma_write_path.sv */
`default_nettype none
`timescale 1ns/1ps

`include "dma_defs.svh"

module dma_write_path
  import dma_pkg::*;
#(
  parameter logic [`DMA_THREAD_ID_W-1:0] THREAD_ID = '0
) (
  input  wire dma_cfg_t                cfg,

  input  wire logic                    rd_rsp_vld,
  input  wire dma_rsp_t                rd_rsp,
  output logic                         rd_rsp_rdy,

  output logic                         wr_req_vld,
  output dma_req_t                     wr_req,
  input  wire logic                    wr_req_rdy,

  output logic                         clear,
  output logic      [`DMA_SLOT_W-1:0]  clear_slot,
  input  wire logic [`DMA_CNT_W-1:0]   clear_offset
);

  localparam int PAD_W  = `DMA_ADDR_W - `DMA_CNT_W - `DMA_WORD_OFFSET;
  localparam int HALF_W = `DMA_MASK_W / 2;

  dma_mode_e               mode;
  logic [`DMA_ADDR_W-1:0]  wr_addr;
  logic [`DMA_MASK_W-1:0]  wr_mask;

  assign mode = (cfg.src_addr == cfg.dst_addr) ? MODE_PREFETCH : MODE_RW;

  // ======================================================================
  // Handshake and tag release

  always_comb begin
    if (mode == MODE_RW) begin
      wr_req_vld = rd_rsp_vld;
      rd_rsp_rdy = wr_req_rdy;                // Stalled write holds the response
      clear      = rd_rsp_vld & wr_req_rdy;
    end else begin
      wr_req_vld = 1'b0;
      rd_rsp_rdy = 1'b1;                      // Prefetch data is dropped
      clear      = rd_rsp_vld;
    end
  end

  assign clear_slot = rd_rsp.tag.slot;

  // ======================================================================
  // Write request

  assign wr_addr = cfg.dst_addr + {{PAD_W{1'b0}}, clear_offset, {`DMA_WORD_OFFSET{1'b0}}};

  always_comb begin
    if (cfg.use_8b) begin
      wr_mask = '1;
    end else if (wr_addr[`DMA_WORD_OFFSET]) begin
      wr_mask = {{HALF_W{1'b1}}, {HALF_W{1'b0}}};  // Upper word of the beat
    end else begin
      wr_mask = {{HALF_W{1'b0}}, {HALF_W{1'b1}}};
    end
  end

  always_comb begin
    wr_req.tag.thread_id = THREAD_ID;
    wr_req.tag.slot      = rd_rsp.tag.slot;
    wr_req.req_type      = REQ_WRITE;
    wr_req.addr          = wr_addr;
    wr_req.wdata         = rd_rsp.rdata;
    wr_req.mask          = wr_mask;
  end

endmodule

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
# Build and run the DMA thread testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module dma_thread_tb -f dma_thread.f

status=0
out=$(./obj_dir/Vdma_thread_tb 2>&1) || status=$?
echo "$out"

if grep -qx "PASS: all tests" <<< "$out"; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed (exit status $status)"
  exit 1
fi

/* testbench/dma_mem_model.sv */
`default_nettype none
`timescale 1ns/1ps

`include "dma_defs.svh"

module dma_mem_model
  import dma_pkg::*;
(
  input  wire logic      clk,
  input  wire logic      rstn,
  input  wire logic      rd_req_vld,
  input  wire dma_req_t  rd_req,
  output logic           rd_req_rdy = 1'b0,
  output logic           rd_rsp_vld = 1'b0,
  output dma_rsp_t       rd_rsp = '0,
  input  wire logic      rd_rsp_rdy,
  output logic           wr_req_rdy = 1'b0
);

  typedef struct packed {
    dma_tag_t                tag;
    logic [`DMA_ADDR_W-1:0]  addr;
    logic [3:0]              wait_cyc;
  } pend_t;

  pend_t pend_q[$];                       // Reads waiting for their response

  function automatic logic [`DMA_DATA_W-1:0] data_pattern(input logic [`DMA_ADDR_W-1:0] addr);
    return {~addr, addr ^ 32'h3C5A_96E1};
  endfunction

  always @(posedge clk) begin : responder
    pend_t p;
    int    pick;
    if (!rstn) begin
      pend_q.delete();
      rd_req_rdy <= 1'b0;
      rd_rsp_vld <= 1'b0;
      wr_req_rdy <= 1'b0;
    end else begin
      rd_req_rdy <= ($urandom_range(3, 0) != 0);   // Ready about 3 cycles in 4
      wr_req_rdy <= ($urandom_range(3, 0) != 0);
      foreach (pend_q[i]) begin
        if (pend_q[i].wait_cyc != 4'd0) begin
          pend_q[i].wait_cyc = pend_q[i].wait_cyc - 4'd1;
        end
      end
      // Held response stays put until it transfers
      if (!rd_rsp_vld || rd_rsp_rdy) begin
        pick = -1;
        foreach (pend_q[i]) begin
          if (pick < 0 && pend_q[i].wait_cyc == 4'd0) begin
            pick = i;
          end
        end
        if (pick >= 0) begin
          rd_rsp_vld   <= 1'b1;
          rd_rsp.tag   <= pend_q[pick].tag;
          rd_rsp.rdata <= data_pattern(pend_q[pick].addr);
          pend_q.delete(pick);
        end else begin
          rd_rsp_vld <= 1'b0;
        end
      end
      if (rd_req_vld && rd_req_rdy) begin
        p.tag      = rd_req.tag;
        p.addr     = rd_req.addr;
        p.wait_cyc = 4'($urandom_range(6, 1));   // Latency 1 to 6 cycles
        pend_q.push_back(p);
      end
    end
  end

endmodule

`default_nettype wire

/* testbench/dma_thread_asserts.sv */
`default_nettype none
`timescale 1ns/1ps

`include "dma_defs.svh"

module dma_thread_asserts
  import dma_pkg::*;
(
  input  wire logic                       clk,
  input  wire logic                       rstn,
  input  wire logic                       rd_req_vld,
  input  wire dma_req_t                   rd_req,
  input  wire logic                       rd_req_rdy,
  input  wire logic                       take,
  input  wire logic [`DMA_SLOT_W-1:0]     set_slot,
  input  wire logic [`DMA_NUM_SLOTS-1:0]  in_use,
  input  wire logic                       clear,
  input  wire logic [`DMA_SLOT_W-1:0]     clear_slot
);

  a_set_on_free: assert property (@(posedge clk) disable iff (!rstn)
    take |-> !in_use[set_slot])
    else $error("tag set on a slot that is already in use");

  a_clear_on_used: assert property (@(posedge clk) disable iff (!rstn)
    clear |-> in_use[clear_slot])
    else $error("tag cleared on a slot that is already free");

  a_rd_vld_known: assert property (@(posedge clk) disable iff (!rstn)
    !$isunknown(rd_req_vld))
    else $error("rd_req_vld is unknown");

  // Request and its tag stay put until the handshake
  a_rd_req_held: assert property (@(posedge clk) disable iff (!rstn)
    rd_req_vld && !rd_req_rdy |=> rd_req_vld && $stable(rd_req))
    else $error("read request changed before it was accepted");

endmodule

// Tag table state is reached through u_tags
bind dma_thread dma_thread_asserts u_asserts (
  .clk        (clk),
  .rstn       (rstn),
  .rd_req_vld (rd_req_vld),
  .rd_req     (rd_req),
  .rd_req_rdy (rd_req_rdy),
  .take       (alloc_take),
  .set_slot   (free_slot),
  .in_use     (u_tags.in_use),
  .clear      (clear),
  .clear_slot (clear_slot)
);

`default_nettype wire

/* testbench/dma_thread_tb.sv */
`default_nettype none
`timescale 1ns/1ps

`include "dma_defs.svh"

module dma_thread_tb
  import dma_pkg::*;
();

  localparam int NUM_CMDS  = 7;
  localparam int MAX_WORDS = 64;          // Destination words tracked per command
  localparam logic [`DMA_THREAD_ID_W-1:0] THREAD_ID = 2'd1;

  typedef struct packed {
    logic [`DMA_ADDR_W-1:0]  src;
    logic [`DMA_ADDR_W-1:0]  dst;
    logic [`DMA_ADDR_W-1:0]  len;
    logic                    use_8b;
    logic [`DMA_RPT_W-1:0]   rpt_less_1;
    logic [`DMA_ADDR_W-1:0]  grp;
    logic [`DMA_ADDR_W-1:0]  stride;
    logic [15:0]             exp_writes;
  } cmd_t;

  logic      clk;
  logic      rstn;
  logic      start;
  dma_cfg_t  cfg;
  logic      rd_req_vld, rd_req_rdy;
  dma_req_t  rd_req;
  logic      rd_rsp_vld, rd_rsp_rdy;
  dma_rsp_t  rd_rsp;
  logic      wr_req_vld, wr_req_rdy;
  dma_req_t  wr_req;
  logic      done;
  logic      idle;

  cmd_t                    cmd_tab [NUM_CMDS];
  logic [`DMA_DATA_W-1:0]  exp_data [MAX_WORDS];
  logic [`DMA_MASK_W-1:0]  exp_mask [MAX_WORDS];
  logic                    exp_used [MAX_WORDS];
  logic                    seen [MAX_WORDS];
  int unsigned             exp_count;
  int unsigned             wr_count;
  int unsigned             cycle_cnt;
  int unsigned             cycle_limit;

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  dma_thread #(
    .THREAD_ID  (THREAD_ID)
  ) uut (
    .clk        (clk),
    .rstn       (rstn),
    .cfg        (cfg),
    .start      (start),
    .rd_req_vld (rd_req_vld),
    .rd_req     (rd_req),
    .rd_req_rdy (rd_req_rdy),
    .rd_rsp_vld (rd_rsp_vld),
    .rd_rsp     (rd_rsp),
    .rd_rsp_rdy (rd_rsp_rdy),
    .wr_req_vld (wr_req_vld),
    .wr_req     (wr_req),
    .wr_req_rdy (wr_req_rdy),
    .done       (done),
    .idle       (idle)
  );

  dma_mem_model u_mem (
    .clk        (clk),
    .rstn       (rstn),
    .rd_req_vld (rd_req_vld),
    .rd_req     (rd_req),
    .rd_req_rdy (rd_req_rdy),
    .rd_rsp_vld (rd_rsp_vld),
    .rd_rsp     (rd_rsp),
    .rd_rsp_rdy (rd_rsp_rdy),
    .wr_req_rdy (wr_req_rdy)
  );

  // ======================================================================
  // Reference rules

  function automatic logic [`DMA_DATA_W-1:0] data_pattern(input logic [`DMA_ADDR_W-1:0] addr);
    return {~addr, addr ^ 32'h3C5A_96E1};
  endfunction

  // Length in words, rounded up to whole elements
  function automatic int unsigned elem_words(input cmd_t c);
    int unsigned step;
    step = c.use_8b ? 2 : 1;
    return ((c.len + 4 * step - 1) / (4 * step)) * step;
  endfunction

  function automatic cmd_t make_row(input logic [31:0] src, input logic [31:0] dst,
                                    input logic [31:0] len, input logic use_8b,
                                    input logic [3:0] rpt, input logic [31:0] grp,
                                    input logic [31:0] stride, input logic [15:0] n);
    cmd_t c;
    c.src        = src;
    c.dst        = dst;
    c.len        = len;
    c.use_8b     = use_8b;
    c.rpt_less_1 = rpt;
    c.grp        = grp;
    c.stride     = stride;
    c.exp_writes = n;
    return c;
  endfunction

  task automatic load_table();
    cmd_tab[0] = make_row(32'h1000, 32'h8000, 32'd40, 1'b0, 4'd0, 32'd16, 32'd16, 16'd10);
    cmd_tab[1] = make_row(32'h2000, 32'h9000, 32'd44, 1'b1, 4'd0, 32'd16, 32'd16, 16'd6);
    cmd_tab[2] = make_row(32'h3000, 32'hA000, 32'd64, 1'b0, 4'd0, 32'd8, 32'd16, 16'd8);
    cmd_tab[3] = make_row(32'h4000, 32'hB000, 32'd24, 1'b0, 4'd2, 32'd8, 32'd8, 16'd18);
    cmd_tab[4] = make_row(32'h5000, 32'h5000, 32'd32, 1'b0, 4'd0, 32'd16, 32'd16, 16'd0);
    cmd_tab[5] = make_row(32'h6000, 32'hC000, 32'd64, 1'b1, 4'd1, 32'd8, 32'd24, 16'd6);
    cmd_tab[6] = make_row(32'h7004, 32'hD00C, 32'd70, 1'b0, 4'd0, 32'd8, 32'd8, 16'd18);
  endtask

  // k-th word read lands at destination plus 4k
  task automatic build_expect(input cmd_t c);
    int unsigned step, words, depth, stride_w, idx, grp, tot;
    logic [`DMA_ADDR_W-1:0] daddr;
    for (int k = 0; k < MAX_WORDS; k++) begin
      exp_used[k] = 1'b0;
      seen[k]     = 1'b0;
    end
    exp_count = 0;
    wr_count  = 0;
    step      = c.use_8b ? 2 : 1;
    words     = elem_words(c);
    depth     = c.grp / 4;
    stride_w  = c.stride / 4;
    tot       = 0;
    if (c.src != c.dst) begin                // Prefetch gives no writes
      for (int p = 0; p <= int'(c.rpt_less_1); p++) begin
        idx = 0;
        grp = 0;
        while (idx < words) begin
          daddr         = c.dst + 4 * tot;
          exp_used[tot] = 1'b1;
          exp_data[tot] = data_pattern(c.src + 4 * idx);
          if (c.use_8b) begin
            exp_mask[tot] = 8'hFF;
          end else begin
            exp_mask[tot] = daddr[2] ? 8'hF0 : 8'h0F;
          end
          exp_count++;
          tot += step;
          grp += step;
          idx += step;
          if (grp == depth) begin
            grp = 0;
            idx = idx + stride_w - depth;    // Next gather group
          end
        end
      end
    end
  endtask

  // ======================================================================
  // Checking

  task automatic stop_on_error();
    $display("FAIL: see errors above");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("ERR t=%0t %s got=0x%0h exp=0x%0h", $time, name, got, exp);
      stop_on_error();
    end
  endtask

  always @(posedge clk) begin : scoreboard
    logic [`DMA_ADDR_W-1:0] off;
    int unsigned            k;
    if (rstn && wr_req_vld && wr_req_rdy) begin
      off = wr_req.addr - cfg.dst_addr;
      k   = off >> 2;
      if (off[1:0] != 2'b00 || k >= MAX_WORDS) begin
        $display("Write to 0x%0h falls outside the destination range", wr_req.addr);
        stop_on_error();
      end else if (!exp_used[k]) begin
        $display("Write to 0x%0h was not expected", wr_req.addr);
        stop_on_error();
      end else if (seen[k]) begin
        $display("Write to 0x%0h was issued twice", wr_req.addr);
        stop_on_error();
      end else begin
        check_val("wr_req.wdata", wr_req.wdata, exp_data[k]);
        check_val("wr_req.mask", 64'(wr_req.mask), 64'(exp_mask[k]));
        check_val("wr_req.req_type", 64'(wr_req.req_type), 64'(REQ_WRITE));
        check_val("wr_req.tag.thread_id", 64'(wr_req.tag.thread_id), 64'(THREAD_ID));
        seen[k] = 1'b1;
        wr_count++;
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= cycle_limit) begin
      $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
      stop_on_error();
    end
  end

  // ======================================================================
  // Command loop

  task automatic run_cmd(input int r);
    cmd_t     c;
    dma_cfg_t nc;
    c = cmd_tab[r];
    build_expect(c);
    check_val("expected write count", 64'(exp_count), 64'(c.exp_writes));
    check_val("idle", 64'(idle), 64'd1);
    nc.src_addr     = c.src;
    nc.dst_addr     = c.dst;
    nc.length_bytes = c.len;
    nc.use_8b       = c.use_8b;
    nc.rpt_less_1   = c.rpt_less_1;
    nc.grp_depth    = c.grp;
    nc.stride       = c.stride;
    cfg   <= nc;
    start <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
    do begin
      @(posedge clk);
    end while (!done);
    @(posedge clk);
    check_val("idle", 64'(idle), 64'd1);
    check_val("rd_req_vld", 64'(rd_req_vld), 64'd0);
    check_val("write count", 64'(wr_count), 64'(c.exp_writes));
    for (int k = 0; k < MAX_WORDS; k++) begin
      if (exp_used[k] && !seen[k]) begin
        $display("Command %0d never wrote destination word %0d", r, k);
        stop_on_error();
      end
    end
  endtask

  initial begin
    int unsigned total_words;
    void'($urandom(6612));
    rstn      = 1'b0;
    start     = 1'b0;
    cfg       = '0;
    cycle_cnt = 0;
    load_table();
    total_words = 0;
    for (int r = 0; r < NUM_CMDS; r++) begin
      total_words += elem_words(cmd_tab[r]) * (int'(cmd_tab[r].rpt_less_1) + 1);
    end
    cycle_limit = 40 * total_words;
    repeat (2) @(posedge clk);
    rstn <= 1'b1;
    @(posedge clk);
    check_val("idle", 64'(idle), 64'd1);
    check_val("rd_req_vld", 64'(rd_req_vld), 64'd0);
    for (int r = 0; r < NUM_CMDS; r++) begin
      run_cmd(r);
    end
    $display("PASS: all tests");
    $finish;
  end

endmodule

`default_nettype wire
